// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_simple_system
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_simple_system.sv ====
`default_nettype none

module tb_simple_system import sys_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic              clk_i = 1'b0;
  logic              arst_n_i;
  logic              data_req_i;
  logic              data_gnt_o;
  logic [ADDR_W-1:0] data_addr_i;
  logic              data_we_i;
  logic [BE_W-1:0]   data_be_i;
  logic [DATA_W-1:0] data_wdata_i;
  logic              data_rvalid_o;
  logic [DATA_W-1:0] data_rdata_o;
  logic              data_err_o;
  logic              instr_req_i;
  logic [ADDR_W-1:0] instr_addr_i;
  logic              instr_rvalid_o;
  logic [DATA_W-1:0] instr_rdata_o;
  logic              timer_irq_o;
  logic              char_valid_o;
  logic [7:0]        char_o;
  logic              halt_o;

  // Expectations driven together with each request
  logic              exp_chk;
  logic              exp_err;
  logic              exp_char;
  logic              exp_halt;
  logic [DATA_W-1:0] exp_rdata;
  logic [DATA_W-1:0] exp_fetch;

  // Expected response, one cycle behind acceptance
  logic              acc_q;
  logic              rsp_chk_q;
  logic              rsp_err_q;
  logic [DATA_W-1:0] rsp_rdata_q;
  logic              fetch_q;
  logic [DATA_W-1:0] fetch_rdata_q;
  logic              char_wr_q;
  logic [7:0]        char_q;
  logic              halt_q;
  logic [DATA_W-1:0] last_rdata;
  int                outstanding;
  int                char_count;

  logic [DATA_W-1:0] ram_model [logic [ADDR_W-1:0]];
  logic [ADDR_W-1:0] addrs [16];
  logic [DATA_W-1:0] t0;
  logic [DATA_W-1:0] t1;
  string             msg;
  int                seed;
  int                err_count;
  int                errs;
  int                chars_before;
  int                tests_passed;
  int                tests_failed;

  simple_system u_dut (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .data_req_i     (data_req_i),
    .data_gnt_o     (data_gnt_o),
    .data_addr_i    (data_addr_i),
    .data_we_i      (data_we_i),
    .data_be_i      (data_be_i),
    .data_wdata_i   (data_wdata_i),
    .data_rvalid_o  (data_rvalid_o),
    .data_rdata_o   (data_rdata_o),
    .data_err_o     (data_err_o),
    .instr_req_i    (instr_req_i),
    .instr_addr_i   (instr_addr_i),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rdata_o  (instr_rdata_o),
    .timer_irq_o    (timer_irq_o),
    .char_valid_o   (char_valid_o),
    .char_o         (char_o),
    .halt_o         (halt_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_q       <= 1'b0;
      rsp_chk_q   <= 1'b0;
      rsp_err_q   <= 1'b0;
      rsp_rdata_q <= '0;
      fetch_q     <= 1'b0;
      char_wr_q   <= 1'b0;
      char_q      <= '0;
      halt_q      <= 1'b0;
      last_rdata  <= '0;
      outstanding <= 0;
      char_count  <= 0;
    end else begin
      acc_q     <= data_req_i & data_gnt_o;
      fetch_q   <= instr_req_i;
      char_wr_q <= data_req_i & data_gnt_o & exp_char;
      if (data_req_i && data_gnt_o) begin
        rsp_chk_q   <= exp_chk;
        rsp_err_q   <= exp_err;
        rsp_rdata_q <= exp_rdata;
        if (exp_char) begin
          char_q <= data_wdata_i[7:0];
        end
        if (exp_halt) begin
          halt_q <= 1'b1;
        end
      end
      if (instr_req_i) begin
        fetch_rdata_q <= exp_fetch;
      end
      if (data_rvalid_o) begin
        last_rdata <= data_rdata_o;
      end
      if (char_valid_o) begin
        char_count <= char_count + 1;
      end
      if (data_req_i && data_gnt_o && !data_rvalid_o) begin
        outstanding <= outstanding + 1;
      end else if (!(data_req_i && data_gnt_o) && data_rvalid_o) begin
        outstanding <= outstanding - 1;
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERR %s: expected 0x%08h, got 0x%08h at %0t", name, expected, actual, $time);
    err_count++;
  endtask

  a_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_gnt_o == data_req_i)
    else report_mismatch("data_gnt_o", 32'($sampled(data_req_i)), 32'($sampled(data_gnt_o)));

  a_data_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_rvalid_o == acc_q)
    else report_mismatch("data_rvalid_o", 32'($sampled(acc_q)), 32'($sampled(data_rvalid_o)));

  a_data_err: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_rvalid_o |-> data_err_o == rsp_err_q)
    else report_mismatch("data_err_o", 32'($sampled(rsp_err_q)), 32'($sampled(data_err_o)));

  a_data_rdata: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (data_rvalid_o && rsp_chk_q) |-> data_rdata_o == rsp_rdata_q)
    else report_mismatch("data_rdata_o", $sampled(rsp_rdata_q), $sampled(data_rdata_o));

  a_instr_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_rvalid_o == fetch_q)
    else report_mismatch("instr_rvalid_o", 32'($sampled(fetch_q)),
                         32'($sampled(instr_rvalid_o)));

  a_instr_rdata: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_rvalid_o |-> instr_rdata_o == fetch_rdata_q)
    else report_mismatch("instr_rdata_o", $sampled(fetch_rdata_q), $sampled(instr_rdata_o));

  // One strobe per accepted character write, with its byte
  a_char_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    char_valid_o == char_wr_q)
    else report_mismatch("char_valid_o", 32'($sampled(char_wr_q)),
                         32'($sampled(char_valid_o)));

  a_char: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    char_valid_o |-> char_o == char_q)
    else report_mismatch("char_o", 32'($sampled(char_q)), 32'($sampled(char_o)));

  a_halt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    halt_o == halt_q)
    else report_mismatch("halt_o", 32'($sampled(halt_q)), 32'($sampled(halt_o)));

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic drive_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                              input logic [31:0] wdata, input logic chk,
                              input logic [31:0] rdata, input logic err);
    data_req_i   = 1'b1;
    data_addr_i  = addr;
    data_we_i    = we;
    data_be_i    = be;
    data_wdata_i = wdata;
    exp_chk      = chk;
    exp_rdata    = rdata;
    exp_err      = err;
    // Control block decode seen from the bus side
    exp_char = we && be[0] && addr == SIMCTRL_BASE + 32'(SC_CHAR);
    exp_halt = we && be[0] && wdata[0] && addr == SIMCTRL_BASE + 32'(SC_HALT);
  endtask

  task automatic drive_idle();
    drive_access('0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
    data_req_i = 1'b0;
  endtask

  // Write data comes back as the old word, left unchecked
  task automatic drive_ram_write(input logic [31:0] addr, input logic [3:0] be,
                                 input logic [31:0] wdata);
    logic [31:0] old_word;
    old_word = ram_model.exists(addr) ? ram_model[addr] : '0;
    ram_model[addr] = merge_bytes(old_word, wdata, be);
    drive_access(addr, 1'b1, be, wdata, 1'b0, '0, 1'b0);
  endtask

  task automatic drive_ram_read(input logic [31:0] addr);
    drive_access(addr, 1'b0, 4'hF, '0, 1'b1, ram_model[addr], 1'b0);
  endtask

  task automatic drive_fetch(input logic [31:0] addr);
    instr_req_i  = 1'b1;
    instr_addr_i = addr;
    exp_fetch    = ram_model[addr];
  endtask

  task automatic fetch_idle();
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    exp_fetch    = '0;
  endtask

  task automatic wait_bus_idle(input int limit);
    int n;
    n = 0;
    while (outstanding != 0 && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (outstanding != 0) begin
      $display("Timeout: %0d bus responses still missing after %0d cycles", outstanding, limit);
      err_count++;
    end
  endtask

  task automatic wait_irq(input logic level, input int limit);
    int n;
    n = 0;
    while (timer_irq_o !== level && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (timer_irq_o !== level) begin
      $display("Timeout: timer interrupt did not go to %0b within %0d cycles", level, limit);
      err_count++;
    end
  endtask

  task automatic wait_halt(input int limit);
    int n;
    n = 0;
    while (halt_o !== 1'b1 && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (halt_o !== 1'b1) begin
      $display("Timeout: halt did not rise within %0d cycles", limit);
      err_count++;
    end
  endtask

  // Single timer read, value taken from the response
  task automatic timer_read(input logic [31:0] addr, output logic [31:0] rdata);
    @(negedge clk_i);
    drive_access(addr, 1'b0, 4'hF, '0, 1'b0, '0, 1'b0);
    @(negedge clk_i);
    drive_idle();
    wait_bus_idle(8);
    rdata = last_rdata;
  endtask

  task automatic check_low(input string name, input logic value);
    assert (value == 1'b0) else report_mismatch(name, 32'h0, 32'(value));
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s, %0d errors", name, err_count - errs_before);
    end
  endtask

  initial begin
    seed         = 32'h3634_dca7;
    err_count    = 0;
    tests_passed = 0;
    tests_failed = 0;
    arst_n_i     = 1'b0;
    drive_idle();
    fetch_idle();
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    errs = err_count;
    @(negedge clk_i);
    check_low("data_rvalid_o", data_rvalid_o);
    check_low("instr_rvalid_o", instr_rvalid_o);
    check_low("timer_irq_o", timer_irq_o);
    check_low("char_valid_o", char_valid_o);
    check_low("halt_o", halt_o);
    finish_test("outputs low after reset", errs);

    // Full-word fill first so partial writes merge into known data
    errs = err_count;
    for (int i = 0; i < 16; i++) begin
      addrs[i] = RAM_BASE | ($random(seed) & 32'h000F_FFFC);
    end
    for (int i = 0; i < 16; i++) begin
      @(negedge clk_i);
      drive_ram_write(addrs[i], 4'hF, addrs[i] ^ 32'h5A5A_A5A5);
    end
    for (int i = 0; i < 16; i++) begin
      @(negedge clk_i);
      drive_ram_write(addrs[i], 4'($random(seed)), 32'($random(seed)));
    end
    for (int i = 0; i < 16; i++) begin
      @(negedge clk_i);
      drive_ram_read(addrs[i]);
    end
    @(negedge clk_i);
    drive_idle();
    wait_bus_idle(8);
    finish_test("random RAM writes and reads", errs);

    errs = err_count;
    for (int i = 0; i < 16; i++) begin
      @(negedge clk_i);
      drive_ram_read(addrs[i]);
      drive_fetch(addrs[15-i]);
    end
    @(negedge clk_i);
    drive_idle();
    fetch_idle();
    wait_bus_idle(8);
    finish_test("fetch during data reads", errs);

    errs = err_count;
    @(negedge clk_i);
    drive_access(32'h0000_1000, 1'b0, 4'hF, '0, 1'b1, '0, 1'b1);
    @(negedge clk_i);
    drive_access(32'h8000_0000, 1'b1, 4'hF, 32'hDEAD_BEEF, 1'b1, '0, 1'b1);
    @(negedge clk_i);
    drive_access(TIMER_BASE + 32'h10, 1'b0, 4'hF, '0, 1'b0, '0, 1'b1);
    @(negedge clk_i);
    drive_ram_read(addrs[0]);
    @(negedge clk_i);
    drive_idle();
    wait_bus_idle(8);
    finish_test("error responses", errs);

    errs = err_count;
    timer_read(TIMER_BASE + 32'(TMR_MTIME_LO), t0);
    timer_read(TIMER_BASE + 32'(TMR_MTIME_LO), t1);
    assert (t1 > t0) else begin
      $display("mtime did not advance between reads, 0x%08h then 0x%08h", t0, t1);
      err_count++;
    end
    @(negedge clk_i);
    drive_access(TIMER_BASE + 32'(TMR_CMP_LO), 1'b1, 4'hF, t1 + 32'd50, 1'b0, '0, 1'b0);
    @(negedge clk_i);
    drive_access(TIMER_BASE + 32'(TMR_CMP_HI), 1'b1, 4'hF, '0, 1'b0, '0, 1'b0);
    @(negedge clk_i);
    drive_idle();
    // Compare lies 50 ticks past the last read
    wait_irq(1'b1, 60);
    @(negedge clk_i);
    drive_access(TIMER_BASE + 32'(TMR_CMP_HI), 1'b1, 4'hF, '1, 1'b0, '0, 1'b0);
    @(negedge clk_i);
    drive_idle();
    wait_irq(1'b0, 4);
    wait_bus_idle(8);
    finish_test("timer compare interrupt", errs);

    errs         = err_count;
    chars_before = char_count;
    msg          = "Hi!\n";
    for (int i = 0; i < msg.len(); i++) begin
      @(negedge clk_i);
      drive_access(SIMCTRL_BASE + 32'(SC_CHAR), 1'b1, 4'h1, {24'h0, msg[i]}, 1'b1, '0, 1'b0);
    end
    @(negedge clk_i);
    drive_idle();
    wait_bus_idle(8);
    assert (char_count - chars_before == msg.len()) else begin
      $display("Saw %0d character strobes for %0d writes", char_count - chars_before,
               msg.len());
      err_count++;
    end
    @(negedge clk_i);
    drive_access(SIMCTRL_BASE + 32'(SC_HALT), 1'b1, 4'hF, 32'h1, 1'b1, '0, 1'b0);
    @(negedge clk_i);
    drive_idle();
    wait_halt(4);
    // Clearing bit 0 must not release halt
    @(negedge clk_i);
    drive_access(SIMCTRL_BASE + 32'(SC_HALT), 1'b1, 4'hF, 32'h0, 1'b1, '0, 1'b0);
    @(negedge clk_i);
    drive_idle();
    repeat (4) @(negedge clk_i);
    wait_bus_idle(8);
    finish_test("console and halt", errs);

    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/bus_xbar.sv ====
`default_nettype none

module bus_xbar import sys_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  // Single host
  input  logic                  host_req_i,
  output logic                  host_gnt_o,
  input  logic [ADDR_W-1:0]     host_addr_i,
  input  logic                  host_we_i,
  input  logic [BE_W-1:0]       host_be_i,
  input  logic [DATA_W-1:0]     host_wdata_i,
  output logic                  host_rvalid_o,
  output logic [DATA_W-1:0]     host_rdata_o,
  output logic                  host_err_o,

  // Devices
  output logic [NR_DEVICES-1:0] dev_req_o,
  output logic [ADDR_W-1:0]     dev_addr_o,
  output logic                  dev_we_o,
  output logic [BE_W-1:0]       dev_be_o,
  output logic [DATA_W-1:0]     dev_wdata_o,
  input  logic [NR_DEVICES-1:0] dev_rvalid_i,
  input  logic [DATA_W-1:0]     dev_rdata_i [NR_DEVICES],
  input  logic [NR_DEVICES-1:0] dev_err_i
);

  logic [NR_DEVICES-1:0] match;
  logic                  hit;
  bus_device_e           sel;

  // Response steering state
  logic                  rsp_mapped_q;
  logic                  rsp_unmapped_q;
  bus_device_e           rsp_dev_q;

  // No other host to arbitrate against
  assign host_gnt_o = host_req_i;

  assign match[DEV_RAM]     = (host_addr_i & RAM_MASK) == RAM_BASE;
  assign match[DEV_SIMCTRL] = (host_addr_i & SIMCTRL_MASK) == SIMCTRL_BASE;
  assign match[DEV_TIMER]   = (host_addr_i & TIMER_MASK) == TIMER_BASE;

  // Lowest matching index wins, the map has no overlaps anyway
  always_comb begin
    hit = 1'b0;
    sel = DEV_RAM;
    for (int i = 0; i < NR_DEVICES; i++) begin
      if (!hit && match[i]) begin
        hit = 1'b1;
        sel = bus_device_e'(i);
      end
    end
  end

  always_comb begin
    dev_req_o = '0;
    if (host_req_i && hit) begin
      dev_req_o[sel] = 1'b1;
    end
  end

  // Shared request payload
  assign dev_addr_o  = host_addr_i;
  assign dev_we_o    = host_we_i;
  assign dev_be_o    = host_be_i;
  assign dev_wdata_o = host_wdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_mapped_q   <= 1'b0;
      rsp_unmapped_q <= 1'b0;
      rsp_dev_q      <= DEV_RAM;
    end else begin
      rsp_mapped_q   <= host_req_i & hit;
      rsp_unmapped_q <= host_req_i & ~hit;
      if (host_req_i && hit) begin
        rsp_dev_q <= sel;
      end
    end
  end

  // Unmapped accesses are answered here with an error and zero data
  assign host_rvalid_o = rsp_unmapped_q | (rsp_mapped_q & dev_rvalid_i[rsp_dev_q]);
  assign host_rdata_o  = rsp_mapped_q ? dev_rdata_i[rsp_dev_q] : '0;
  assign host_err_o    = rsp_unmapped_q |
                         (rsp_mapped_q & dev_rvalid_i[rsp_dev_q] & dev_err_i[rsp_dev_q]);

  a_req_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(dev_req_o));

  for (genvar i = 0; i < NR_DEVICES; i++) begin : g_rsp_check
    a_rsp_from_selected: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      dev_rvalid_i[i] |-> (rsp_mapped_q && rsp_dev_q == bus_device_e'(i)));
  end

endmodule

`default_nettype wire

// ==== src/ram_2p.sv ====
`default_nettype none

module ram_2p import sys_pkg::*; #(
  parameter int DEPTH = RAM_DEPTH
) (
  input  logic              clk_i,
  input  logic              arst_n_i,

  // Port A, data bus
  input  logic              a_req_i,
  input  logic              a_we_i,
  input  logic [BE_W-1:0]   a_be_i,
  input  logic [ADDR_W-1:0] a_addr_i,
  input  logic [DATA_W-1:0] a_wdata_i,
  output logic              a_rvalid_o,
  output logic [DATA_W-1:0] a_rdata_o,

  // Port B, instruction fetch
  input  logic              b_req_i,
  input  logic [ADDR_W-1:0] b_addr_i,
  output logic              b_rvalid_o,
  output logic [DATA_W-1:0] b_rdata_o
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [IDX_W-1:0]  a_idx;
  logic [IDX_W-1:0]  b_idx;

  // Word index wraps at the memory depth
  assign a_idx = IDX_W'((a_addr_i >> 2) % DEPTH);
  assign b_idx = IDX_W'((b_addr_i >> 2) % DEPTH);

  // Port A returns the old word on a write
  always_ff @(posedge clk_i) begin
    if (a_req_i) begin
      a_rdata_o <= mem[a_idx];
      if (a_we_i) begin
        mem[a_idx] <= byte_merge(mem[a_idx], a_wdata_i, a_be_i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_req_i) begin
      b_rdata_o <= mem[b_idx];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_rvalid_o <= 1'b0;
      b_rvalid_o <= 1'b0;
    end else begin
      a_rvalid_o <= a_req_i;
      b_rvalid_o <= b_req_i;
    end
  end

  a_rvalid_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown({a_rvalid_o, b_rvalid_o}));

endmodule

`default_nettype wire

// ==== src/sim_ctrl.sv ====
`default_nettype none

module sim_ctrl import sys_pkg::*; (
  input  logic              clk_i,
  input  logic              arst_n_i,

  input  logic              req_i,
  input  logic              we_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,

  output logic              char_valid_o,
  output logic [7:0]        char_o,
  output logic              halt_o
);

  logic char_wr;
  logic halt_wr;

  // Only the low byte lane carries the character and the halt bit
  assign char_wr = req_i & we_i & be_i[0] & (addr_i[9:0] == SC_CHAR);
  assign halt_wr = req_i & we_i & be_i[0] & (addr_i[9:0] == SC_HALT) & wdata_i[0];

  // Nothing readable here
  assign rdata_o = '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_o     <= 1'b0;
      char_valid_o <= 1'b0;
      halt_o       <= 1'b0;
    end else begin
      rvalid_o     <= req_i;
      char_valid_o <= char_wr;
      // Sticky until reset
      if (halt_wr) begin
        halt_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (char_wr) begin
      char_o <= wdata_i[7:0];
    end
  end

endmodule

`default_nettype wire

// ==== src/simple_system.sv ====
`default_nettype none

module simple_system import sys_pkg::*; (
  input  logic              clk_i,
  input  logic              arst_n_i,

  // Data port
  input  logic              data_req_i,
  output logic              data_gnt_o,
  input  logic [ADDR_W-1:0] data_addr_i,
  input  logic              data_we_i,
  input  logic [BE_W-1:0]   data_be_i,
  input  logic [DATA_W-1:0] data_wdata_i,
  output logic              data_rvalid_o,
  output logic [DATA_W-1:0] data_rdata_o,
  output logic              data_err_o,

  // Fetch port
  input  logic              instr_req_i,
  input  logic [ADDR_W-1:0] instr_addr_i,
  output logic              instr_rvalid_o,
  output logic [DATA_W-1:0] instr_rdata_o,

  output logic              timer_irq_o,
  output logic              char_valid_o,
  output logic [7:0]        char_o,
  output logic              halt_o
);

  logic [NR_DEVICES-1:0] dev_req;
  logic [ADDR_W-1:0]     dev_addr;
  logic                  dev_we;
  logic [BE_W-1:0]       dev_be;
  logic [DATA_W-1:0]     dev_wdata;
  logic [NR_DEVICES-1:0] dev_rvalid;
  logic [DATA_W-1:0]     dev_rdata [NR_DEVICES];
  logic [NR_DEVICES-1:0] dev_err;

  // RAM and control block never signal an error
  assign dev_err[DEV_RAM]     = 1'b0;
  assign dev_err[DEV_SIMCTRL] = 1'b0;

  bus_xbar u_bus (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .host_req_i    (data_req_i),
    .host_gnt_o    (data_gnt_o),
    .host_addr_i   (data_addr_i),
    .host_we_i     (data_we_i),
    .host_be_i     (data_be_i),
    .host_wdata_i  (data_wdata_i),
    .host_rvalid_o (data_rvalid_o),
    .host_rdata_o  (data_rdata_o),
    .host_err_o    (data_err_o),
    .dev_req_o     (dev_req),
    .dev_addr_o    (dev_addr),
    .dev_we_o      (dev_we),
    .dev_be_o      (dev_be),
    .dev_wdata_o   (dev_wdata),
    .dev_rvalid_i  (dev_rvalid),
    .dev_rdata_i   (dev_rdata),
    .dev_err_i     (dev_err)
  );

  // Shared instruction and data memory
  ram_2p #(
    .DEPTH (RAM_DEPTH)
  ) u_ram (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .a_req_i    (dev_req[DEV_RAM]),
    .a_we_i     (dev_we),
    .a_be_i     (dev_be),
    .a_addr_i   (dev_addr),
    .a_wdata_i  (dev_wdata),
    .a_rvalid_o (dev_rvalid[DEV_RAM]),
    .a_rdata_o  (dev_rdata[DEV_RAM]),
    .b_req_i    (instr_req_i),
    .b_addr_i   (instr_addr_i),
    .b_rvalid_o (instr_rvalid_o),
    .b_rdata_o  (instr_rdata_o)
  );

  timer u_timer (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (dev_req[DEV_TIMER]),
    .we_i     (dev_we),
    .be_i     (dev_be),
    .addr_i   (dev_addr),
    .wdata_i  (dev_wdata),
    .rvalid_o (dev_rvalid[DEV_TIMER]),
    .rdata_o  (dev_rdata[DEV_TIMER]),
    .err_o    (dev_err[DEV_TIMER]),
    .irq_o    (timer_irq_o)
  );

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (dev_req[DEV_SIMCTRL]),
    .we_i         (dev_we),
    .be_i         (dev_be),
    .addr_i       (dev_addr),
    .wdata_i      (dev_wdata),
    .rvalid_o     (dev_rvalid[DEV_SIMCTRL]),
    .rdata_o      (dev_rdata[DEV_SIMCTRL]),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

endmodule

`default_nettype wire

// ==== src/sys_pkg.sv ====
`default_nettype none

package sys_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // Devices on the data bus
  localparam int NR_DEVICES = 3;

  typedef enum logic [1:0] {
    DEV_RAM,
    DEV_SIMCTRL,
    DEV_TIMER
  } bus_device_e;

  // Address map, base plus mask of the bits above the device window
  localparam logic [ADDR_W-1:0] RAM_BASE     = 32'h0010_0000;
  localparam logic [ADDR_W-1:0] RAM_MASK     = 32'hFFF0_0000;
  localparam logic [ADDR_W-1:0] SIMCTRL_BASE = 32'h0002_0000;
  localparam logic [ADDR_W-1:0] SIMCTRL_MASK = 32'hFFFF_FC00;
  localparam logic [ADDR_W-1:0] TIMER_BASE   = 32'h0003_0000;
  localparam logic [ADDR_W-1:0] TIMER_MASK   = 32'hFFFF_FC00;

  // 1 MB of 32-bit words
  localparam int RAM_DEPTH = 262144;

  // Timer register offsets
  localparam logic [9:0] TMR_MTIME_LO = 10'h000;
  localparam logic [9:0] TMR_MTIME_HI = 10'h004;
  localparam logic [9:0] TMR_CMP_LO   = 10'h008;
  localparam logic [9:0] TMR_CMP_HI   = 10'h00C;

  // Simulation control register offsets
  localparam logic [9:0] SC_CHAR = 10'h000;
  localparam logic [9:0] SC_HALT = 10'h008;

  // Replace the enabled bytes of a word
  function automatic logic [DATA_W-1:0] byte_merge(input logic [DATA_W-1:0] old_word,
                                                   input logic [DATA_W-1:0] new_word,
                                                   input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] merged;
    merged = old_word;
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) begin
        merged[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

// ==== src/timer.sv ====
`default_nettype none

module timer import sys_pkg::*; (
  input  logic              clk_i,
  input  logic              arst_n_i,

  input  logic              req_i,
  input  logic              we_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o,

  output logic              irq_o
);

  logic [9:0]        offset;
  logic              wr_en;
  logic              off_ok;
  logic [DATA_W-1:0] rdata_d;

  logic [63:0]       mtime_q;
  logic [63:0]       mtime_d;
  logic [63:0]       mtimecmp_q;
  logic [63:0]       mtimecmp_d;

  // Device window is 1 kB
  assign offset = addr_i[9:0];
  assign wr_en  = req_i & we_i;

  // Counter runs every cycle unless software loads it
  always_comb begin
    mtime_d = mtime_q + 64'd1;
    if (wr_en && offset == TMR_MTIME_LO) begin
      mtime_d[31:0] = byte_merge(mtime_q[31:0], wdata_i, be_i);
    end
    if (wr_en && offset == TMR_MTIME_HI) begin
      mtime_d[63:32] = byte_merge(mtime_q[63:32], wdata_i, be_i);
    end
  end

  always_comb begin
    mtimecmp_d = mtimecmp_q;
    if (wr_en && offset == TMR_CMP_LO) begin
      mtimecmp_d[31:0] = byte_merge(mtimecmp_q[31:0], wdata_i, be_i);
    end
    if (wr_en && offset == TMR_CMP_HI) begin
      mtimecmp_d[63:32] = byte_merge(mtimecmp_q[63:32], wdata_i, be_i);
    end
  end

  // Read mux, anything else is an error
  always_comb begin
    rdata_d = '0;
    off_ok  = 1'b1;
    case (offset)
      TMR_MTIME_LO: rdata_d = mtime_q[31:0];
      TMR_MTIME_HI: rdata_d = mtime_q[63:32];
      TMR_CMP_LO:   rdata_d = mtimecmp_q[31:0];
      TMR_CMP_HI:   rdata_d = mtimecmp_q[63:32];
      default:      off_ok  = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_o      <= 1'b0;
      rvalid_o   <= 1'b0;
      err_o      <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      irq_o      <= mtime_q >= mtimecmp_q;
      rvalid_o   <= req_i;
      err_o      <= req_i & ~off_ok;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rdata_d;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/sys_pkg.sv
src/bus_xbar.sv
src/ram_2p.sv
src/timer.sv
src/sim_ctrl.sv
src/simple_system.sv
dv/tb_simple_system.sv
